// ==== compile.f ====
opn_timing_pkg.sv
opn_reg_decode.sv
opn_clk_div.sv
opn_timer.sv
opn_status.sv
opn_timing_top.sv
tb_clkgen.sv
tb_opn_timing.sv

// ==== Makefile ====
# Verilator build and run for the OPN timing core
TOP := tb_opn_timing

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

obj_dir/V$(TOP): compile.f $(wildcard *.sv)
	verilator --binary --timing --timescale 1ns/1ps --top-module $(TOP) -f compile.f

test: obj_dir/V$(TOP)
	@out=$$(./obj_dir/V$(TOP) 2>&1); echo "$$out"; \
	echo "$$out" | grep -qF '*** TEST PASSED ***'

clean:
	rm -rf obj_dir

// ==== tb_opn_timing.sv ====
/* OPN timing core testbench */
module tb_opn_timing import opn_timing_pkg::*; ;
    timeunit 1ns;
    timeprecision 1ps;

    // longest timer B period is 24576 cycles at /6, four of them plus margin
    localparam int MAX_CYCLES = 200000;

    // event slots: clk_en bits 4..0, then timer flags and busy
    localparam logic [2:0] F_EN55 = 3'd0, F_ADPCM3 = 3'd1, F_ADPCM = 3'd2;
    localparam logic [2:0] F_SSG = 3'd3, F_FM = 3'd4;
    localparam logic [2:0] EV_TA = 3'd5, EV_TB = 3'd6, EV_BUSY = 3'd7;

    logic       clk, rst, cen, wr, a0;
    logic [7:0] din;
    clk_en_t    clk_en;
    logic       irq_n;
    logic [7:0] status;

    logic        cen_q, rst_q;      // as seen by the DUT at posedge
    logic [4:0]  en_v;
    logic [2:0]  k;
    logic [1:0]  flags_q;
    logic        busy_q;
    int          gap[8], meas[8], cnt_ev[8];
    int          fm_tot, ta_mark, tb_mark, busy_fm;
    int          cycles = 0;
    int unsigned seed;

    tb_clkgen #(.PERIOD(4.0)) u_clkgen (.clk(clk));

    opn_timing_top uut (
        .clk    (clk),
        .rst    (rst),
        .cen    (cen),
        .wr     (wr),
        .a0     (a0),
        .din    (din),
        .clk_en (clk_en),
        .irq_n  (irq_n),
        .status (status)
    );

    // expected spacing, from the prescaler table
    function automatic int exp_fm_interval(input div_sel_t sel);
        casez (sel)
            2'b0?:   return 2;
            2'b10:   return 6;
            default: return 3;
        endcase
    endfunction

    function automatic int exp_ssg_interval(input div_sel_t sel);
        casez (sel)
            2'b0?:   return 1;
            2'b10:   return 4;
            default: return 2;
        endcase
    endfunction

    function automatic int exp_timer_a(input timer_a_t v);
        return 1024 - int'(v);              // fm pulses from value to wrap
    endfunction

    function automatic int exp_timer_b(input timer_b_t v);
        return TB_PRESCALE * (256 - int'(v));
    endfunction

    task automatic report_error(input string msg);
        $display("FAILED at %0t ns: %s", $time, msg);
        $display("*** TEST FAILED ***");
        $fatal(1, "stopped at first mismatch");
    endtask

    task automatic check_interval(input string what, input int got, input int exp);
        if (got != exp)
            report_error($sformatf("%s is %0d, expected %0d", what, got, exp));
    endtask

    task automatic check_status(input logic [7:0] got, input logic [7:0] exp);
        if (got !== exp)
            report_error($sformatf("status is %02h, expected %02h", got, exp));
    endtask

    task automatic check_irq(input logic got, input logic exp);
        if (got !== exp)
            report_error($sformatf("irq_n is %b, expected %b", got, exp));
    endtask

    // address cycle then data cycle
    task automatic write_reg(input logic [7:0] addr, input logic [7:0] data);
        @(negedge clk);
        wr  = 1'b1;
        a0  = 1'b0;
        din = addr;
        @(negedge clk);
        a0  = 1'b1;
        din = data;
        @(negedge clk);
        wr  = 1'b0;
        a0  = 1'b0;
        din = 8'h00;
    endtask

    task automatic select_div(input logic [7:0] addr);
        @(negedge clk);
        wr  = 1'b1;         // address only, no busy
        a0  = 1'b0;
        din = addr;
        @(negedge clk);
        wr  = 1'b0;
        din = 8'h00;
    endtask

    // counts move on negedge, so read them on posedge
    task automatic wait_events(input logic [2:0] idx, input int n);
        int target;
        @(posedge clk);
        target = cnt_ev[idx] + n;
        while (cnt_ev[idx] < target)
            @(posedge clk);
    endtask

    task automatic wait_not_busy();
        @(negedge clk);
        while (status[7])
            @(negedge clk);
    endtask

    task automatic check_rates(input div_sel_t sel);
        wait_events(F_FM, 4);       // old tc gone after two wraps
        check_interval("fm interval", meas[F_FM], exp_fm_interval(sel));
        check_interval("ssg interval", meas[F_SSG], exp_ssg_interval(sel));
    endtask

    task automatic check_adpcm_gaps();
        check_interval("adpcm interval", meas[F_ADPCM], ADPCM_DIV);
        check_interval("adpcm3 interval", meas[F_ADPCM3], ADPCM_DIV * ADPCM3_DIV);
        check_interval("en55 interval", meas[F_EN55],
                       ADPCM_DIV * ADPCM3_DIV * ADPCM55_DIV);
    endtask

    // random cen until enough 55 kHz pulses, ends on posedge
    task automatic run_gated(input int n55);
        int target;
        @(posedge clk);
        target = cnt_ev[F_EN55] + n55;
        while (cnt_ev[F_EN55] < target) begin
            @(negedge clk);
            cen = ($urandom_range(3, 0) != 0);  // about 3 in 4 high
            @(posedge clk);
        end
    endtask

    always @(posedge clk) begin
        cen_q = cen;
        rst_q = rst;
    end

    // interval monitor, outputs are stable at negedge
    always @(negedge clk) begin
        en_v = clk_en;
        if (rst_q) begin
            for (int i = 0; i < 8; i++) begin
                k         = 3'(i);
                gap[k]    = 0;
                meas[k]   = 0;
                cnt_ev[k] = 0;
            end
            fm_tot  = 0;
            ta_mark = 0;
            tb_mark = 0;
            busy_fm = 0;
            flags_q = 2'b00;
            busy_q  = 1'b0;
        end else begin
            for (int i = 0; i < 5; i++) begin
                k = 3'(i);
                if (cen_q)
                    gap[k] = gap[k] + 1;    // cen-high edges since last pulse
                if (en_v[k]) begin
                    meas[k]   = gap[k];
                    cnt_ev[k] = cnt_ev[k] + 1;
                    gap[k]    = 0;
                end
            end
            if (status[0] && !flags_q[0]) begin  // flag A rise
                meas[EV_TA]   = fm_tot - ta_mark;
                ta_mark       = fm_tot;
                cnt_ev[EV_TA] = cnt_ev[EV_TA] + 1;
            end
            if (status[1] && !flags_q[1]) begin
                meas[EV_TB]   = fm_tot - tb_mark;
                tb_mark       = fm_tot;
                cnt_ev[EV_TB] = cnt_ev[EV_TB] + 1;
            end
            if (status[7]) begin
                if (!busy_q)
                    busy_fm = 0;
                if (clk_en.fm)
                    busy_fm = busy_fm + 1;  // fm pulses that count busy down
            end else if (busy_q) begin
                meas[EV_BUSY]   = busy_fm;
                cnt_ev[EV_BUSY] = cnt_ev[EV_BUSY] + 1;
            end
            if (clk_en.fm)
                fm_tot = fm_tot + 1;
            flags_q = status[1:0];
            busy_q  = status[7];
        end
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout: run did not finish within %0d clock cycles", MAX_CYCLES);
            $display("*** TEST FAILED ***");
            $fatal(1, "timeout");
        end
    end

    initial begin
        timer_a_t va;
        timer_b_t vb;
        int       ta_before;
        seed = $urandom(21);
        rst  = 1'b1;
        cen  = 1'b1;
        wr   = 1'b0;
        a0   = 1'b0;
        din  = 8'h00;
        repeat (10) @(negedge clk);
        rst = 1'b0;

        // reset state and default /6
        @(negedge clk);
        check_status(status, 8'h00);
        check_irq(irq_n, 1'b1);
        check_rates(DIV_SEL_6);

        select_div(REG_DIV2);
        check_rates(DIV_SEL_2);
        select_div(REG_DIV3);
        check_rates(DIV_SEL_3);
        select_div(REG_DIV6);
        check_rates(DIV_SEL_6);

        // ADPCM cascade, steady then gated cen
        wait_events(F_EN55, 3);
        check_adpcm_gaps();
        run_gated(3);
        check_adpcm_gaps();
        check_interval("gated fm interval", meas[F_FM], exp_fm_interval(DIV_SEL_6));
        check_interval("gated ssg interval", meas[F_SSG], exp_ssg_interval(DIV_SEL_6));
        @(negedge clk);
        cen = 1'b1;

        // timers at /2 keep the run short
        select_div(REG_DIV2);
        va = timer_a_t'($urandom_range(980, 600));
        vb = timer_b_t'($urandom_range(240, 200));  // three B periods outlast one A period

        write_reg(REG_TA_HI, va[9:2]);
        write_reg(REG_TA_LO, {6'd0, va[1:0]});
        write_reg(REG_TCTRL, 8'h05);        // load_a, flag_en_a
        for (int n = 1; n <= 3; n++) begin
            wait_events(EV_TA, 1);
            @(negedge clk);
            check_status(status, 8'h01);
            check_irq(irq_n, 1'b0);
            if (n > 1)
                check_interval("timer A period", meas[EV_TA], exp_timer_a(va));
            write_reg(REG_TCTRL, 8'h15);    // clr_a pulse
            @(negedge clk);
            check_status(status, 8'h80);
            check_irq(irq_n, 1'b1);
        end

        // timer B with timer A still running but its flag off
        write_reg(REG_TB, vb);
        write_reg(REG_TCTRL, 8'h0b);        // load_a, load_b, flag_en_b
        @(posedge clk);
        ta_before = cnt_ev[EV_TA];
        for (int n = 1; n <= 3; n++) begin
            wait_events(EV_TB, 1);
            @(negedge clk);
            check_status(status, 8'h02);
            check_irq(irq_n, 1'b0);
            if (n > 1)
                check_interval("timer B period", meas[EV_TB], exp_timer_b(vb));
            write_reg(REG_TCTRL, 8'h2b);    // clr_b pulse
            @(negedge clk);
            check_status(status, 8'h80);
            check_irq(irq_n, 1'b1);
        end
        @(posedge clk);
        check_interval("timer A flag events while disabled", cnt_ev[EV_TA], ta_before);

        // busy length at /2, then at /6
        wait_not_busy();
        write_reg(REG_TCTRL, 8'h00);        // stop both timers
        check_status(status, 8'h80);
        wait_events(EV_BUSY, 1);
        check_interval("busy length in fm pulses", meas[EV_BUSY], BUSY_CYCLES);
        select_div(REG_DIV6);
        write_reg(REG_TB, 8'($urandom_range(255, 0)));
        check_status(status, 8'h80);
        wait_events(EV_BUSY, 1);
        check_interval("busy length in fm pulses", meas[EV_BUSY], BUSY_CYCLES);

        @(negedge clk);
        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

// ==== tb_clkgen.sv ====
/* testbench clock source */
module tb_clkgen #(
    parameter real PERIOD = 4.0     // ns
) (
    output logic clk
);
    timeunit 1ns;
    timeprecision 1ps;

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2.0) clk = ~clk;   // 50% duty
    end

endmodule

// ==== opn_timing_top.sv ====
/* OPN timing core top */
module opn_timing_top import opn_timing_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       cen,
    input  logic       wr,
    input  logic       a0,     // 0 address, 1 data
    input  logic [7:0] din,
    output clk_en_t    clk_en,
    output logic       irq_n,
    output logic [7:0] status
);

    timer_ctrl_t ctrl;
    div_sel_t    div_sel;
    logic        data_wr;
    logic        ovf_a, ovf_b;

    opn_reg_decode u_reg_decode (
        .clk     (clk),
        .rst     (rst),
        .wr      (wr),
        .a0      (a0),
        .din     (din),
        .ctrl    (ctrl),
        .div_sel (div_sel),
        .data_wr (data_wr)
    );

    opn_clk_div u_clk_div (
        .clk     (clk),
        .rst     (rst),
        .cen     (cen),
        .div_sel (div_sel),
        .clk_en  (clk_en)
    );

    // timer A, one step per fm pulse
    opn_timer #(
        .cnt_t    (timer_a_t),
        .STEP_DIV (1)
    ) u_timer_a (
        .clk   (clk),
        .rst   (rst),
        .tick  (clk_en.fm),
        .load  (ctrl.load_a),
        .value (ctrl.value_a),
        .ovf   (ovf_a)
    );

    // timer B, extra /16 ahead of the counter
    opn_timer #(
        .cnt_t    (timer_b_t),
        .STEP_DIV (TB_PRESCALE)
    ) u_timer_b (
        .clk   (clk),
        .rst   (rst),
        .tick  (clk_en.fm),
        .load  (ctrl.load_b),
        .value (ctrl.value_b),
        .ovf   (ovf_b)
    );

    opn_status u_status (
        .clk       (clk),
        .rst       (rst),
        .tick      (clk_en.fm),
        .data_wr   (data_wr),
        .ovf_a     (ovf_a),
        .ovf_b     (ovf_b),
        .flag_en_a (ctrl.flag_en_a),
        .flag_en_b (ctrl.flag_en_b),
        .clr_a     (ctrl.clr_a),
        .clr_b     (ctrl.clr_b),
        .irq_n     (irq_n),
        .status    (status)
    );

endmodule

// ==== opn_status.sv ====
/* timer flags, irq and busy */
module opn_status import opn_timing_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       tick,      // fm enable
    input  logic       data_wr,
    input  logic       ovf_a,
    input  logic       ovf_b,
    input  logic       flag_en_a,
    input  logic       flag_en_b,
    input  logic       clr_a,
    input  logic       clr_b,
    output logic       irq_n,
    output logic [7:0] status
);

    logic              flag_a, flag_b;
    logic [BUSY_W-1:0] busy_cnt;
    logic              busy;

    // sticky flags, set wins over clear
    always_ff @(posedge clk) begin
        if (rst) begin
            flag_a <= 1'b0;
            flag_b <= 1'b0;
        end else begin
            if (ovf_a && flag_en_a)
                flag_a <= 1'b1;
            else if (clr_a)
                flag_a <= 1'b0;
            if (ovf_b && flag_en_b)
                flag_b <= 1'b1;
            else if (clr_b)
                flag_b <= 1'b0;
        end
    end

    // busy counts fm pulses down from the last data write
    always_ff @(posedge clk) begin
        if (rst)
            busy_cnt <= '0;
        else if (data_wr)
            busy_cnt <= BUSY_W'(BUSY_CYCLES);  // restart on each write
        else if (tick && busy)
            busy_cnt <= busy_cnt - BUSY_W'(1);
    end

    assign busy   = busy_cnt != '0;
    assign irq_n  = ~(flag_a | flag_b);   // active low
    assign status = {busy, 5'd0, flag_b, flag_a};

endmodule

// ==== opn_timer.sv ====
/* loadable overflow timer */
module opn_timer #(
    parameter type cnt_t    = logic [7:0],
    parameter int  STEP_DIV = 1
) (
    input  logic clk,
    input  logic rst,
    input  logic tick,    // fm enable
    input  logic load,
    input  cnt_t value,
    output logic ovf
);

    localparam int PW = (STEP_DIV > 1) ? $clog2(STEP_DIV) : 1;

    cnt_t          cnt;
    logic [PW-1:0] pres;      // sub-prescaler
    logic          load_d;
    logic          step;

    assign step = tick & (pres == PW'(STEP_DIV - 1));

    always_ff @(posedge clk) begin
        if (rst) begin
            cnt    <= '0;
            pres   <= '0;
            load_d <= 1'b0;
            ovf    <= 1'b0;
        end else begin
            load_d <= load;
            ovf    <= 1'b0;
            if (load && !load_d) begin
                cnt  <= value;      // start on rising load
                pres <= '0;
            end else if (load && tick) begin
                pres <= step ? '0 : pres + PW'(1);
                if (step) begin
                    if (cnt == cnt_t'('1)) begin
                        cnt <= value;   // reload from latest value
                        ovf <= 1'b1;
                    end else begin
                        cnt <= cnt + cnt_t'(1);
                    end
                end
            end
            // load low holds count and prescaler
        end
    end

endmodule

// ==== opn_clk_div.sv ====
/* clock enable divider */
module opn_clk_div import opn_timing_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  logic     cen,
    input  div_sel_t div_sel,
    output clk_en_t  clk_en
);

    logic [2:0] fm_cnt, fm_tc, fm_tc_nxt;
    logic [1:0] ssg_cnt, ssg_tc, ssg_tc_nxt;
    logic [1:0] adpcm_cnt;   // mod ADPCM_DIV
    logic [1:0] adpcm3_cnt;  // mod ADPCM3_DIV
    logic [2:0] a55_cnt;     // mod ADPCM55_DIV
    logic       fm_wrap, ssg_wrap, adpcm_wrap, adpcm3_wrap;

    // terminal counts from the selection
    always_comb begin
        casez (div_sel)
            2'b0?: begin
                fm_tc_nxt  = FM_TC_DIV2;
                ssg_tc_nxt = SSG_TC_DIV2;
            end
            2'b10: begin
                fm_tc_nxt  = FM_TC_DIV6;
                ssg_tc_nxt = SSG_TC_DIV6;
            end
            default: begin  // 2'b11
                fm_tc_nxt  = FM_TC_DIV3;
                ssg_tc_nxt = SSG_TC_DIV3;
            end
        endcase
    end

    assign fm_wrap     = fm_cnt == fm_tc;
    assign ssg_wrap    = ssg_cnt == ssg_tc;
    assign adpcm_wrap  = adpcm_cnt == 2'(ADPCM_DIV - 1);
    assign adpcm3_wrap = adpcm3_cnt == 2'(ADPCM3_DIV - 1);

    // FM and SSG prescalers, new tc only taken at wrap
    always_ff @(posedge clk) begin
        if (rst) begin
            fm_cnt  <= 3'd0;
            ssg_cnt <= 2'd0;
            fm_tc   <= FM_TC_DIV6;
            ssg_tc  <= SSG_TC_DIV6;
        end else if (cen) begin
            fm_cnt  <= fm_wrap ? 3'd0 : fm_cnt + 3'd1;
            ssg_cnt <= ssg_wrap ? 2'd0 : ssg_cnt + 2'd1;
            if (fm_wrap)
                fm_tc <= fm_tc_nxt;
            if (ssg_wrap)
                ssg_tc <= ssg_tc_nxt;
        end
    end

    // ADPCM cascade, each stage steps on the previous wrap
    always_ff @(posedge clk) begin
        if (rst) begin
            adpcm_cnt  <= 2'd0;
            adpcm3_cnt <= 2'd0;
            a55_cnt    <= 3'd0;
        end else if (cen) begin
            adpcm_cnt <= adpcm_wrap ? 2'd0 : adpcm_cnt + 2'd1;
            if (adpcm_wrap) begin
                adpcm3_cnt <= adpcm3_wrap ? 2'd0 : adpcm3_cnt + 2'd1;
                if (adpcm3_wrap)
                    a55_cnt <= (a55_cnt == 3'(ADPCM55_DIV - 1)) ? 3'd0 : a55_cnt + 3'd1;
            end
        end
    end

    // registered enables, one cycle after the zero count
    always_ff @(posedge clk) begin
        if (rst) begin
            clk_en <= '0;
        end else begin
            clk_en.fm     <= cen & (fm_cnt == 3'd0);
            clk_en.ssg    <= cen & (ssg_cnt == 2'd0);
            clk_en.adpcm  <= cen & (adpcm_cnt == 2'd0);
            clk_en.adpcm3 <= cen & (adpcm_cnt == 2'd0) & (adpcm3_cnt == 2'd0);
            clk_en.en55   <= cen & (adpcm_cnt == 2'd0) & (adpcm3_cnt == 2'd0)
                             & (a55_cnt == 3'd0);   // slowest, gated by both
        end
    end

endmodule

// ==== opn_reg_decode.sv ====
/* register write decode */
module opn_reg_decode import opn_timing_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        wr,
    input  logic        a0,
    input  logic [7:0]  din,
    output timer_ctrl_t ctrl,
    output div_sel_t    div_sel,
    output logic        data_wr
);

    logic [7:0] addr;       // last address written
    logic       addr_wr;

    assign addr_wr = wr & ~a0;
    assign data_wr = wr & a0;   // busy starts on the same edge

    // address latch and prescaler select
    always_ff @(posedge clk) begin
        if (rst) begin
            addr    <= 8'h00;
            div_sel <= DIV_SEL_RST;
        end else if (addr_wr) begin
            addr <= din;
            // prescaler is picked by the address alone
            case (din)
                REG_DIV6: div_sel <= DIV_SEL_6;
                REG_DIV3: div_sel <= DIV_SEL_3;
                REG_DIV2: div_sel <= DIV_SEL_2;
                default:  div_sel <= div_sel;
            endcase
        end
    end

    // timer control fields
    always_ff @(posedge clk) begin
        if (rst) begin
            ctrl <= '0;     // timers stopped, flags off
        end else begin
            ctrl.clr_a <= 1'b0;     // clears only last one cycle
            ctrl.clr_b <= 1'b0;
            if (data_wr) begin
                case (addr)
                    REG_TA_HI: ctrl.value_a[9:2] <= din;
                    REG_TA_LO: ctrl.value_a[1:0] <= din[1:0];
                    REG_TB:    ctrl.value_b      <= din;
                    REG_TCTRL: begin
                        ctrl.load_a    <= din[0];
                        ctrl.load_b    <= din[1];
                        ctrl.flag_en_a <= din[2];
                        ctrl.flag_en_b <= din[3];
                        ctrl.clr_a     <= din[4];   // pulse
                        ctrl.clr_b     <= din[5];
                    end
                    default: ;  // other registers live elsewhere
                endcase
            end
        end
    end

endmodule

// ==== opn_timing_pkg.sv ====
/* OPN timing core package */
package opn_timing_pkg;

    // prescaler selection, written through the address port
    typedef logic [1:0] div_sel_t;     // 2'b0? /2, 2'b10 /6, 2'b11 /3

    localparam div_sel_t DIV_SEL_RST = 2'b10;   // /6 after reset
    localparam div_sel_t DIV_SEL_6   = 2'b10;
    localparam div_sel_t DIV_SEL_3   = 2'b11;
    localparam div_sel_t DIV_SEL_2   = 2'b00;

    // register addresses
    localparam logic [7:0] REG_TA_HI = 8'h24;  // timer A bits 9:2
    localparam logic [7:0] REG_TA_LO = 8'h25;  // timer A bits 1:0
    localparam logic [7:0] REG_TB    = 8'h26;
    localparam logic [7:0] REG_TCTRL = 8'h27;  // load, flag enable, clear
    localparam logic [7:0] REG_DIV6  = 8'h2d;
    localparam logic [7:0] REG_DIV3  = 8'h2e;
    localparam logic [7:0] REG_DIV2  = 8'h2f;

    // divider terminal counts, counter runs 0..tc
    localparam logic [2:0] FM_TC_DIV2  = 3'd1;
    localparam logic [2:0] FM_TC_DIV3  = 3'd2;
    localparam logic [2:0] FM_TC_DIV6  = 3'd5;
    localparam logic [1:0] SSG_TC_DIV2 = 2'd0;  // ssg every cen
    localparam logic [1:0] SSG_TC_DIV3 = 2'd1;
    localparam logic [1:0] SSG_TC_DIV6 = 2'd3;

    // ADPCM cascade
    localparam int ADPCM_DIV   = 4;   // cen per adpcm
    localparam int ADPCM3_DIV  = 3;   // adpcm per adpcm3
    localparam int ADPCM55_DIV = 6;   // adpcm3 per 55 kHz

    localparam int TB_PRESCALE = 16;  // fm pulses per timer B step
    localparam int BUSY_CYCLES = 32;  // fm pulses of busy after a data write
    localparam int BUSY_W      = $clog2(BUSY_CYCLES + 1);

    typedef logic [9:0] timer_a_t;
    typedef logic [7:0] timer_b_t;

    typedef struct packed {
        timer_a_t value_a;
        timer_b_t value_b;
        logic     load_a;     // level, run timer A
        logic     load_b;
        logic     flag_en_a;
        logic     flag_en_b;
        logic     clr_a;      // single cycle
        logic     clr_b;
    } timer_ctrl_t;

    typedef struct packed {
        logic fm;
        logic ssg;
        logic adpcm;
        logic adpcm3;
        logic en55;
    } clk_en_t;

endpackage
